/* include/lsu_defines.svh */
// --------------------------------------------------
// widths and limits of the load/store issue front end
// data path, byte enable, scoreboard id, cause code
// and the Sv39 canonical boundary
// --------------------------------------------------

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data and address width
`define LSU_XLEN 64

// one enable bit per byte of a double word
`define LSU_BE_W 8

// address bits that select a byte within a double word
`define LSU_OFFSET_W 3

// scoreboard transaction id
`define LSU_TRANS_ID_W 3

// operator encoding width
`define LSU_OP_W 4

// exception cause code width
`define LSU_CAUSE_W 6

// Sv39: bits from here up to the msb must all match
`define LSU_SV39_MSB 38

`endif

/* source/lsu_pkg.sv */
// --------------------------------------------------
// load/store front end types
// operator, unit class and cause enums
// request word carried from agu to issue ports
// size and byte-enable helpers
// --------------------------------------------------

`include "lsu_defines.svh"

package lsu_pkg;

    // load and store operators
    typedef enum logic [`LSU_OP_W-1:0] {
        LB  = 4'd0,
        LBU = 4'd1,
        LH  = 4'd2,
        LHU = 4'd3,
        LW  = 4'd4,
        LWU = 4'd5,
        LD  = 4'd6,
        SB  = 4'd8,
        SH  = 4'd9,
        SW  = 4'd10,
        SD  = 4'd11
    } lsu_op_e;

    // which issue port takes the request
    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } lsu_fu_e;

    // privileged spec cause codes
    typedef enum logic [`LSU_CAUSE_W-1:0] {
        LD_ADDR_MISALIGNED = 6'd4,
        LD_ACCESS_FAULT    = 6'd5,
        ST_ADDR_MISALIGNED = 6'd6,
        ST_ACCESS_FAULT    = 6'd7
    } lsu_cause_e;

    // one issued request, valid bit first
    typedef struct packed {
        logic                       valid;
        logic [`LSU_XLEN-1:0]       vaddr;
        logic [`LSU_XLEN-1:0]       wdata;
        logic [`LSU_BE_W-1:0]       be;
        lsu_op_e                    op;
        logic [`LSU_TRANS_ID_W-1:0] trans_id;
        logic                       approx;
    } lsu_req_t;

    // class of an operator, store opcodes have bit 3 set
    function automatic lsu_fu_e op_fu(lsu_op_e op);
        case (op)
            SB, SH, SW, SD: return STORE;
            default:        return LOAD;
        endcase
    endfunction

    // log2 of the byte count
    function automatic logic [1:0] op_size(lsu_op_e op);
        case (op)
            LH, LHU, SH:  return 2'd1;
            LW, LWU, SW:  return 2'd2;
            LD, SD:       return 2'd3;
            default:      return 2'd0;
        endcase
    endfunction

    // 2^size ones moved up to the byte offset, spill past byte 7 dropped
    function automatic logic [`LSU_BE_W-1:0] be_gen(logic [`LSU_OFFSET_W-1:0] offset,
                                                    logic [1:0]               size);
        logic [2*`LSU_BE_W-1:0] ones;
        logic [2*`LSU_BE_W-1:0] mask;
        ones = (16'h1 << (4'd1 << size)) - 16'h1;
        mask = ones << offset;
        return mask[`LSU_BE_W-1:0];
    endfunction

endpackage

/* source/lsu_ctrl_if.sv */
// --------------------------------------------------
// head request and pop pulses between the request
// buffer and its consumers
// --------------------------------------------------

`timescale 1ns/10ps

interface lsu_ctrl_if;

    // oldest request, or the incoming one while empty
    lsu_pkg::lsu_req_t head;
    // retire the head at the next edge
    logic              pop_ld;
    logic              pop_st;
    // no stored entry
    logic              empty;

    // buffer side
    modport buffer (
        output head,
        output empty,
        input  pop_ld,
        input  pop_st
    );

    // dispatch and address check side
    modport disp (
        input  head,
        input  empty,
        output pop_ld,
        output pop_st
    );

endinterface

/* source/lsu_agu.sv */
// --------------------------------------------------
// address generation
// base plus signed immediate, byte enables,
// approximate window flag, request packing
// --------------------------------------------------

`timescale 1ns/10ps

`include "lsu_defines.svh"

module lsu_agu (
    input  logic                       lsu_valid_i,
    input  lsu_pkg::lsu_op_e           operator_i,
    input  logic [`LSU_XLEN-1:0]       operand_a_i,
    input  logic [`LSU_XLEN-1:0]       imm_i,
    input  logic [`LSU_XLEN-1:0]       operand_b_i,
    input  logic [`LSU_XLEN-1:0]       approx_lo_i,
    input  logic [`LSU_XLEN-1:0]       approx_hi_i,
    input  logic [`LSU_TRANS_ID_W-1:0] trans_id_i,
    output lsu_pkg::lsu_req_t          req_o
);

    logic [`LSU_XLEN-1:0] vaddr;
    logic [`LSU_BE_W-1:0] be;
    logic                 approx;

    // --------------------------------------------------
    // address
    // --------------------------------------------------
    // immediate is sign extended upstream, carry out dropped
    assign vaddr = $unsigned($signed(operand_a_i) + $signed(imm_i));

    // byte lanes from the virtual offset, same as physical
    assign be = lsu_pkg::be_gen(vaddr[`LSU_OFFSET_W-1:0], lsu_pkg::op_size(operator_i));

    // inclusive window, address zero never counts
    assign approx = (vaddr != '0) && (vaddr >= approx_lo_i) && (vaddr <= approx_hi_i);

    // --------------------------------------------------
    // request word
    // --------------------------------------------------
    always_comb begin
        req_o.valid    = lsu_valid_i;
        req_o.vaddr    = vaddr;
        // store data rides along for loads too
        req_o.wdata    = operand_b_i;
        req_o.be       = be;
        req_o.op       = operator_i;
        req_o.trans_id = trans_id_i;
        req_o.approx   = approx;
    end

endmodule

/* source/lsu_req_buffer.sv */
// --------------------------------------------------
// two-entry request bypass FIFO
// holds requests while the issue ports stall,
// passes the incoming request through when empty
// --------------------------------------------------

`timescale 1ns/10ps

module lsu_req_buffer (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              valid_i,
    input  lsu_pkg::lsu_req_t req_i,
    lsu_ctrl_if.buffer        ctrl,
    output logic              ready_o
);

    // storage and pointers
    lsu_pkg::lsu_req_t [1:0] mem_d;
    lsu_pkg::lsu_req_t [1:0] mem_q;
    logic                    rd_ptr_d;
    logic                    rd_ptr_q;
    logic                    wr_ptr_d;
    logic                    wr_ptr_q;
    logic [1:0]              cnt_d;
    logic [1:0]              cnt_q;
    logic                    empty;

    assign empty      = (cnt_q == 2'd0);
    assign ctrl.empty = empty;
    // upstream may still send one more in the cycle ready drops
    assign ready_o    = empty;

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        mem_d    = mem_q;
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;

        // every valid request is stored, even one that bypasses
        if (valid_i) begin
            mem_d[wr_ptr_q] = req_i;
            wr_ptr_d        = ~wr_ptr_q;
            cnt_d           = cnt_d + 2'd1;
        end

        // retire head
        if (ctrl.pop_ld) begin
            mem_d[rd_ptr_q].valid = 1'b0;
            rd_ptr_d              = rd_ptr_d + 1'b1;
            cnt_d                 = cnt_d - 2'd1;
        end

        if (ctrl.pop_st) begin
            mem_d[rd_ptr_q].valid = 1'b0;
            rd_ptr_d              = rd_ptr_d + 1'b1;
            cnt_d                 = cnt_d - 2'd1;
        end

        // both ports retired, nothing left
        if (ctrl.pop_ld && ctrl.pop_st) begin
            mem_d = '0;
        end

        if (flush_i) begin
            mem_d    = '0;
            rd_ptr_d = 1'b0;
            wr_ptr_d = 1'b0;
            cnt_d    = 2'd0;
        end
    end

    // head select
    // bypass while empty, so an idle pipe issues in the same cycle
    assign ctrl.head = empty ? req_i : mem_q[rd_ptr_q];

    // --------------------------------------------------
    // registers
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_q    <= '0;
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            mem_q    <= mem_d;
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

endmodule

/* source/lsu_addr_check.sv */
// --------------------------------------------------
// address checks on the head request
// misaligned access by transfer size
// Sv39 canonical access fault with translation on
// --------------------------------------------------

`timescale 1ns/10ps

`include "lsu_defines.svh"

module lsu_addr_check (
    input  logic                translation_en_i,
    lsu_ctrl_if.disp            ctrl,
    output logic                ex_valid_o,
    output lsu_pkg::lsu_cause_e ex_cause_o
);

    lsu_pkg::lsu_fu_e          head_fu;
    logic [1:0]                head_size;
    logic [`LSU_OFFSET_W:0]    size_mask;
    logic                      misaligned;
    logic                      non_canonical;

    assign head_fu   = lsu_pkg::op_fu(ctrl.head.op);
    assign head_size = lsu_pkg::op_size(ctrl.head.op);

    // ones below the size, e.g. 3'b011 for a word
    assign size_mask = (4'd1 << head_size) - 4'd1;

    // byte accesses give an empty mask and never fault
    assign misaligned = |(ctrl.head.vaddr[`LSU_OFFSET_W-1:0] & size_mask[`LSU_OFFSET_W-1:0]);

    // upper field must be all ones or all zeros
    assign non_canonical = !((&ctrl.head.vaddr[`LSU_XLEN-1:`LSU_SV39_MSB]) ||
                             !(|ctrl.head.vaddr[`LSU_XLEN-1:`LSU_SV39_MSB]));

    // --------------------------------------------------
    // cause select
    // --------------------------------------------------
    always_comb begin
        ex_valid_o = 1'b0;
        // don't care while ex_valid_o is low
        ex_cause_o = lsu_pkg::LD_ADDR_MISALIGNED;

        if (ctrl.head.valid) begin
            if (misaligned) begin
                ex_valid_o = 1'b1;
                ex_cause_o = (head_fu == lsu_pkg::STORE) ? lsu_pkg::ST_ADDR_MISALIGNED
                                                         : lsu_pkg::LD_ADDR_MISALIGNED;
            end

            // access fault wins over misaligned
            if (translation_en_i && non_canonical) begin
                ex_valid_o = 1'b1;
                ex_cause_o = (head_fu == lsu_pkg::STORE) ? lsu_pkg::ST_ACCESS_FAULT
                                                         : lsu_pkg::LD_ACCESS_FAULT;
            end
        end
    end

endmodule

/* source/lsu_dispatch.sv */
// --------------------------------------------------
// issue routing
// head request to the load or store port,
// downstream pops back to the buffer
// --------------------------------------------------

`timescale 1ns/10ps

module lsu_dispatch (
    input  logic     ld_pop_i,
    input  logic     st_pop_i,
    lsu_ctrl_if.disp ctrl,
    output logic     ld_valid_o,
    output logic     st_valid_o
);

    lsu_pkg::lsu_fu_e head_fu;
    logic             head_valid;

    assign head_fu = lsu_pkg::op_fu(ctrl.head.op);

    // stored entries are always valid requests
    // while empty the bypassed request carries its own flag
    assign head_valid = ctrl.head.valid || !ctrl.empty;

    // --------------------------------------------------
    // issue valids
    // --------------------------------------------------
    assign ld_valid_o = head_valid && (head_fu == lsu_pkg::LOAD);
    assign st_valid_o = head_valid && (head_fu == lsu_pkg::STORE);

    // pops only count on the port that is issuing
    // a stray pop would retire the wrong entry
    assign ctrl.pop_ld = ld_pop_i && ld_valid_o;
    assign ctrl.pop_st = st_pop_i && st_valid_o;

endmodule

/* source/lsu_top.sv */
// --------------------------------------------------
// load/store issue front end, top level
// agu, bypass buffer, address check, dispatch
// --------------------------------------------------

`timescale 1ns/10ps

`include "lsu_defines.svh"

module lsu_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       lsu_valid_i,
    input  logic                       translation_en_i,
    input  lsu_pkg::lsu_op_e           operator_i,
    input  logic [`LSU_XLEN-1:0]       operand_a_i,
    input  logic [`LSU_XLEN-1:0]       imm_i,
    input  logic [`LSU_XLEN-1:0]       operand_b_i,
    input  logic [`LSU_XLEN-1:0]       approx_lo_i,
    input  logic [`LSU_XLEN-1:0]       approx_hi_i,
    input  logic [`LSU_TRANS_ID_W-1:0] trans_id_i,
    input  logic                       ld_pop_i,
    input  logic                       st_pop_i,
    output logic                       lsu_ready_o,
    output logic                       ld_valid_o,
    output logic                       st_valid_o,
    output logic [`LSU_XLEN-1:0]       req_vaddr_o,
    output logic [`LSU_XLEN-1:0]       req_wdata_o,
    output logic [`LSU_BE_W-1:0]       req_be_o,
    output logic [`LSU_TRANS_ID_W-1:0] req_trans_id_o,
    output logic                       req_approx_o,
    output logic                       req_ex_valid_o,
    output lsu_pkg::lsu_cause_e        req_ex_cause_o
);

    // request from the agu
    lsu_pkg::lsu_req_t agu_req;

    lsu_ctrl_if ctrl ();

    lsu_agu i_agu (
        .lsu_valid_i ( lsu_valid_i ),
        .operator_i  ( operator_i  ),
        .operand_a_i ( operand_a_i ),
        .imm_i       ( imm_i       ),
        .operand_b_i ( operand_b_i ),
        .approx_lo_i ( approx_lo_i ),
        .approx_hi_i ( approx_hi_i ),
        .trans_id_i  ( trans_id_i  ),
        .req_o       ( agu_req     )
    );

    lsu_req_buffer i_req_buffer (
        .clk_i   ( clk_i       ),
        .rst_ni  ( rst_ni      ),
        .flush_i ( flush_i     ),
        .valid_i ( lsu_valid_i ),
        .req_i   ( agu_req     ),
        .ctrl    ( ctrl        ),
        .ready_o ( lsu_ready_o )
    );

    lsu_addr_check i_addr_check (
        .translation_en_i ( translation_en_i ),
        .ctrl             ( ctrl             ),
        .ex_valid_o       ( req_ex_valid_o   ),
        .ex_cause_o       ( req_ex_cause_o   )
    );

    lsu_dispatch i_dispatch (
        .ld_pop_i   ( ld_pop_i   ),
        .st_pop_i   ( st_pop_i   ),
        .ctrl       ( ctrl       ),
        .ld_valid_o ( ld_valid_o ),
        .st_valid_o ( st_valid_o )
    );

    // head fields, vaddr doubles as the faulting address
    assign req_vaddr_o    = ctrl.head.vaddr;
    assign req_wdata_o    = ctrl.head.wdata;
    assign req_be_o       = ctrl.head.be;
    assign req_trans_id_o = ctrl.head.trans_id;
    assign req_approx_o   = ctrl.head.approx;

endmodule

/* sim/lsu_tb.sv */
// --------------------------------------------------
// testbench for the load/store issue front end
// stimulus table with expectations from a small model
// plus a back-pressure and flush sequence
// --------------------------------------------------

`timescale 1ns/10ps

`include "lsu_defines.svh"

module lsu_tb;

    localparam int TIMEOUT  = 20;
    localparam int MAX_ROWS = 48;

    logic clk_i, rst_ni, flush_i, lsu_valid_i, translation_en_i, ld_pop_i, st_pop_i;
    lsu_pkg::lsu_op_e operator_i;
    logic [`LSU_XLEN-1:0] operand_a_i, imm_i, operand_b_i, approx_lo_i, approx_hi_i;
    logic [`LSU_TRANS_ID_W-1:0] trans_id_i;
    logic lsu_ready_o, ld_valid_o, st_valid_o, req_approx_o, req_ex_valid_o;
    logic [`LSU_XLEN-1:0] req_vaddr_o, req_wdata_o;
    logic [`LSU_BE_W-1:0] req_be_o;
    logic [`LSU_TRANS_ID_W-1:0] req_trans_id_o;
    lsu_pkg::lsu_cause_e req_ex_cause_o;

    // stimulus and expected columns, one row per test
    string            name_tab [MAX_ROWS];
    lsu_pkg::lsu_op_e op_tab [MAX_ROWS];
    logic [63:0]      a_tab [MAX_ROWS], imm_tab [MAX_ROWS], b_tab [MAX_ROWS];
    logic [63:0]      lo_tab [MAX_ROWS], hi_tab [MAX_ROWS], exp_addr [MAX_ROWS];
    logic [7:0]       exp_be [MAX_ROWS];
    logic [5:0]       exp_cause [MAX_ROWS];
    logic             ten_tab [MAX_ROWS], pop_tab [MAX_ROWS], exp_ex [MAX_ROWS];
    logic             exp_apx [MAX_ROWS], exp_st [MAX_ROWS];
    int               rows, seed, errors, tests_run, tests_failed;

    lsu_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic int bytes_of(lsu_pkg::lsu_op_e op);
        case (op)
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
            lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::SW: return 4;
            lsu_pkg::LD, lsu_pkg::SD:               return 8;
            default:                                return 1;
        endcase
    endfunction

    function automatic logic is_store(lsu_pkg::lsu_op_e op);
        case (op)
            lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW, lsu_pkg::SD: return 1'b1;
            default:                                            return 1'b0;
        endcase
    endfunction

    // random double-word aligned base, canonical
    function automatic logic [63:0] rnd_base();
        return {32'h0, $random(seed)} & ~64'h7;
    endfunction

    task automatic add_row(input string nm, input lsu_pkg::lsu_op_e op, input logic [63:0] a,
                           input logic [63:0] imm, input logic [63:0] lo, input logic [63:0] hi,
                           input logic ten, input logic pop);
        logic [63:0] addr;
        int          nb;
        int          k;
        logic        mis;
        logic        bad;
        addr = a + imm;
        nb   = bytes_of(op);
        mis  = (addr % nb) != 0;
        // Sv39, upper field must copy bit 38
        bad  = ten && (addr[63:`LSU_SV39_MSB] != {(64-`LSU_SV39_MSB){addr[`LSU_SV39_MSB]}});
        name_tab[rows] = nm;
        op_tab[rows]   = op;
        a_tab[rows]    = a;
        imm_tab[rows]  = imm;
        b_tab[rows]    = {$random(seed), $random(seed)};
        lo_tab[rows]   = lo;
        hi_tab[rows]   = hi;
        ten_tab[rows]  = ten;
        pop_tab[rows]  = pop;
        exp_addr[rows] = addr;
        exp_st[rows]   = is_store(op);
        for (k = 0; k < 8; k++) begin
            exp_be[rows][k] = (k >= addr[2:0]) && (k < addr[2:0] + nb);
        end
        exp_ex[rows]    = mis || bad;
        // access fault beats misaligned
        exp_cause[rows] = bad ? (exp_st[rows] ? 6'd7 : 6'd5) : (exp_st[rows] ? 6'd6 : 6'd4);
        exp_apx[rows]   = (addr != 0) && (addr >= lo) && (addr <= hi);
        rows++;
    endtask

    // --------------------------------------------------
    // drive, wait, check
    // --------------------------------------------------
    task automatic check(input string test, input string what, input logic [63:0] exp,
                         input logic [63:0] act);
        if (exp !== act) begin
            $display("ERROR %s %s: expected %h, actual %h", test, what, exp, act);
            errors++;
        end
    endtask

    task automatic drive_req(input lsu_pkg::lsu_op_e op, input logic [63:0] a,
                             input logic [63:0] imm, input logic [63:0] b, input logic [63:0] lo,
                             input logic [63:0] hi, input logic ten, input logic [2:0] id);
        operator_i       = op;
        operand_a_i      = a;
        imm_i            = imm;
        operand_b_i      = b;
        approx_lo_i      = lo;
        approx_hi_i      = hi;
        translation_en_i = ten;
        trans_id_i       = id;
        lsu_valid_i      = 1'b1;
    endtask

    // one cycle of valid per request, then wait for an issue port
    // cycles returns how many edges passed before it showed up
    task automatic wait_issue(input string test, output int cycles);
        int n;
        n = 0;
        #1;
        while (!(ld_valid_o || st_valid_o) && n < TIMEOUT) begin
            @(negedge clk_i);
            lsu_valid_i = 1'b0;
            #1;
            n++;
        end
        if (!(ld_valid_o || st_valid_o)) begin
            $display("%s: no issue valid appeared within %0d cycles", test, TIMEOUT);
            errors++;
        end
        cycles = n;
    endtask

    task automatic wait_ready(input string test);
        int n;
        n = 0;
        #1;
        while (!lsu_ready_o && n < TIMEOUT) begin
            @(negedge clk_i);
            #1;
            n++;
        end
        if (!lsu_ready_o) begin
            $display("%s: lsu_ready_o stayed low for %0d cycles", test, TIMEOUT);
            errors++;
        end
    endtask

    task automatic close_test(input string test, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", test);
        end else begin
            tests_failed++;
            $display("test %s: failed", test);
        end
    endtask

    task automatic run_row(input int i);
        int errs_before;
        int lat;
        errs_before = errors;
        @(negedge clk_i);
        drive_req(op_tab[i], a_tab[i], imm_tab[i], b_tab[i], lo_tab[i], hi_tab[i],
                  ten_tab[i], i[2:0]);
        wait_issue(name_tab[i], lat);
        // buffer is empty, so the request bypasses in the same cycle
        check(name_tab[i], "issue cycles", 0, lat);
        check(name_tab[i], "st_valid_o", exp_st[i], st_valid_o);
        check(name_tab[i], "ld_valid_o", !exp_st[i], ld_valid_o);
        check(name_tab[i], "vaddr", exp_addr[i], req_vaddr_o);
        check(name_tab[i], "be", exp_be[i], req_be_o);
        check(name_tab[i], "trans_id", i[2:0], req_trans_id_o);
        check(name_tab[i], "ex_valid", exp_ex[i], req_ex_valid_o);
        check(name_tab[i], "approx", exp_apx[i], req_approx_o);
        if (exp_ex[i]) begin
            check(name_tab[i], "ex_cause", exp_cause[i], req_ex_cause_o);
        end
        if (exp_st[i]) begin
            check(name_tab[i], "wdata", b_tab[i], req_wdata_o);
        end
        // retire by pop, or drop it with a flush
        @(negedge clk_i);
        lsu_valid_i = 1'b0;
        ld_pop_i    = pop_tab[i] && !exp_st[i];
        st_pop_i    = pop_tab[i] && exp_st[i];
        flush_i     = !pop_tab[i];
        @(negedge clk_i);
        ld_pop_i = 1'b0;
        st_pop_i = 1'b0;
        flush_i  = 1'b0;
        wait_ready(name_tab[i]);
        check(name_tab[i], "idle valids", 0, {ld_valid_o, st_valid_o});
        close_test(name_tab[i], errs_before);
    endtask

    // --------------------------------------------------
    // back-pressure and flush
    // --------------------------------------------------
    task automatic backpressure_flush();
        int          errs_before;
        int          lat;
        logic [63:0] addr_a;
        logic [63:0] addr_b;
        logic [63:0] wdata_b;
        errs_before = errors;
        addr_a  = rnd_base();
        addr_b  = rnd_base();
        wdata_b = {$random(seed), $random(seed)};
        @(negedge clk_i);
        drive_req(lsu_pkg::LD, addr_a, 64'h0, 64'h0, 64'h0, 64'h0, 1'b0, 3'd1);
        // second request in the cycle ready falls
        @(negedge clk_i);
        drive_req(lsu_pkg::SD, addr_b, 64'h8, wdata_b, 64'h0, 64'h0, 1'b0, 3'd2);
        #1;
        check("backpressure", "ready after first", 0, lsu_ready_o);
        @(negedge clk_i);
        lsu_valid_i = 1'b0;
        repeat (3) @(negedge clk_i);
        #1;
        check("backpressure", "held ld_valid_o", 1, ld_valid_o);
        check("backpressure", "held vaddr", addr_a, req_vaddr_o);
        check("backpressure", "held ready", 0, lsu_ready_o);
        @(negedge clk_i);
        ld_pop_i = 1'b1;
        @(negedge clk_i);
        ld_pop_i = 1'b0;
        wait_issue("backpressure", lat);
        // next entry is the head one cycle after the pop
        check("backpressure", "second issue cycles", 0, lat);
        check("backpressure", "second st_valid_o", 1, st_valid_o);
        check("backpressure", "second vaddr", addr_b + 64'h8, req_vaddr_o);
        check("backpressure", "second wdata", wdata_b, req_wdata_o);
        @(negedge clk_i);
        st_pop_i = 1'b1;
        @(negedge clk_i);
        st_pop_i = 1'b0;
        wait_ready("backpressure");
        // another pair, then flushed
        @(negedge clk_i);
        drive_req(lsu_pkg::SW, addr_a, 64'h4, wdata_b, 64'h0, 64'h0, 1'b0, 3'd3);
        @(negedge clk_i);
        drive_req(lsu_pkg::LB, addr_b, 64'h1, 64'h0, 64'h0, 64'h0, 1'b0, 3'd4);
        @(negedge clk_i);
        lsu_valid_i = 1'b0;
        #1;
        check("flush", "ready before flush", 0, lsu_ready_o);
        check("flush", "st_valid_o before flush", 1, st_valid_o);
        @(negedge clk_i);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        #1;
        check("flush", "valids after flush", 0, {ld_valid_o, st_valid_o});
        check("flush", "ready after flush", 1, lsu_ready_o);
        close_test("backpressure_flush", errs_before);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int off;
        int i;
        int errs_before;
        seed = 13;
        {errors, tests_run, tests_failed, rows} = '0;
        {rst_ni, flush_i, lsu_valid_i, translation_en_i, ld_pop_i, st_pop_i} = '0;
        operator_i = lsu_pkg::LB;
        {operand_a_i, imm_i, operand_b_i, approx_lo_i, approx_hi_i, trans_id_i} = '0;

        // aligned load bypass
        add_row("ld_aligned", lsu_pkg::LD, rnd_base(), 64'd16, 0, 0, 1'b1, 1'b1);
        add_row("lw_aligned", lsu_pkg::LW, rnd_base(), 64'd4, 0, 0, 1'b1, 1'b1);
        add_row("ld_neg_imm", lsu_pkg::LD, 64'h1000, -64'sd8, 0, 0, 1'b1, 1'b1);
        add_row("ld_flushed", lsu_pkg::LD, rnd_base(), 64'd8, 0, 0, 1'b0, 1'b0);
        // every legal store offset
        for (off = 0; off < 8; off++) begin
            add_row($sformatf("sb_off%0d", off), lsu_pkg::SB, rnd_base(), off, 0, 0, 1'b0, 1'b1);
        end
        for (off = 0; off < 8; off += 2) begin
            add_row($sformatf("sh_off%0d", off), lsu_pkg::SH, rnd_base(), off, 0, 0, 1'b0, 1'b1);
        end
        add_row("sw_off0", lsu_pkg::SW, rnd_base(), 64'd0, 0, 0, 1'b0, 1'b1);
        add_row("sw_off4", lsu_pkg::SW, rnd_base(), 64'd4, 0, 0, 1'b0, 1'b1);
        add_row("sd_off0", lsu_pkg::SD, rnd_base(), 64'd0, 0, 0, 1'b0, 1'b1);
        // misalignment
        add_row("lh_off1", lsu_pkg::LH, rnd_base(), 64'd1, 0, 0, 1'b0, 1'b1);
        add_row("lhu_off3", lsu_pkg::LHU, rnd_base(), 64'd3, 0, 0, 1'b0, 1'b1);
        add_row("lw_off2", lsu_pkg::LW, rnd_base(), 64'd2, 0, 0, 1'b0, 1'b1);
        add_row("lwu_off6", lsu_pkg::LWU, rnd_base(), 64'd6, 0, 0, 1'b0, 1'b1);
        add_row("ld_off4", lsu_pkg::LD, rnd_base(), 64'd4, 0, 0, 1'b0, 1'b1);
        add_row("lbu_off3", lsu_pkg::LBU, rnd_base(), 64'd3, 0, 0, 1'b0, 1'b1);
        add_row("sw_off1", lsu_pkg::SW, rnd_base(), 64'd1, 0, 0, 1'b0, 1'b1);
        add_row("sd_off5", lsu_pkg::SD, rnd_base(), 64'd5, 0, 0, 1'b0, 1'b1);
        // canonical checks
        add_row("ld_noncanon", lsu_pkg::LD, 64'h0000_0080_0000_0000, 64'd4, 0, 0, 1'b1, 1'b1);
        add_row("sw_noncanon", lsu_pkg::SW, 64'hffff_0000_0000_0000, 64'd2, 0, 0, 1'b1, 1'b1);
        add_row("ld_notrans", lsu_pkg::LD, 64'h0000_0080_0000_0000, 64'd0, 0, 0, 1'b0, 1'b1);
        add_row("ld_canon_hi", lsu_pkg::LD, 64'hffff_ffc0_0000_0000, 64'd8, 0, 0, 1'b1, 1'b1);
        // approximate window
        add_row("ld_apx_lo", lsu_pkg::LD, 64'h1000, 64'd0, 64'h1000, 64'h1fff, 1'b0, 1'b1);
        add_row("sd_apx_in", lsu_pkg::SD, 64'h1ff0, 64'd8, 64'h1000, 64'h1fff, 1'b0, 1'b1);
        add_row("ld_apx_out", lsu_pkg::LD, 64'h2000, 64'd0, 64'h1000, 64'h1fff, 1'b0, 1'b1);
        add_row("lb_apx_zero", lsu_pkg::LB, 64'h0, 64'd0, 64'h0, 64'h100, 1'b0, 1'b1);

        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        errs_before = errors;
        @(negedge clk_i);
        #1;
        check("reset", "lsu_ready_o", 1, lsu_ready_o);
        check("reset", "valids", 0, {ld_valid_o, st_valid_o});
        close_test("reset", errs_before);

        for (i = 0; i < rows; i++) begin
            run_row(i);
        end
        backpressure_flush();

        $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
                 tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
source/lsu_pkg.sv
source/lsu_ctrl_if.sv
source/lsu_agu.sv
source/lsu_req_buffer.sv
source/lsu_addr_check.sv
source/lsu_dispatch.sv
source/lsu_top.sv
sim/lsu_tb.sv
